/* Makefile */
.PHONY: all compile run clean

all: run

compile:
	verilator --binary --timing --assert --top-module controllerTb -f controller.f -Mdir obj_dir

run: compile
	./obj_dir/VcontrollerTb

clean:
	rm -rf obj_dir

/* bench/controllerTb.sv */
`default_nettype none

module controllerTb;

	localparam int resetCycles = 3;
	localparam int fieldReps = 4;	// random register fields per funct
	localparam int branchReps = 8;	// flag patterns per branch
	localparam int unknownWords = 100;
	localparam int burstWords = 200;
	localparam int cycleLimit = resetCycles + 1 + 24 * fieldReps + 4 + 14 * 2
		+ 6 * branchReps + 6 + unknownWords + burstWords + 20;
	localparam logic [5:0] opSpecial2 = 6'b011100;	// mul, madd, msub group
	localparam logic [5:0] opSpecial3 = 6'b011111;	// seb, seh group

	logic clk = 1'b0;
	logic rst;
	logic inValid;
	isaPkg::instrWord instruction;
	logic equalVal;
	logic gtZero;
	logic ltZero;
	logic rtIsZero;
	logic outValid;
	logic [controlPkg::ctrlWidth-1:0] controlBits;
	logic [1:0] jump;
	logic branch;
	logic pcSrc;

	logic expValid;
	logic [16:0] expResult;	// {ctrl, jump, branch, pcSrc}
	logic [31:0] lfsrState;
	int cycles;

	logic [5:0] keptFuncts[24] = '{isaPkg::fnSll, isaPkg::fnSrl, isaPkg::fnSra,
		isaPkg::fnSllv, isaPkg::fnSrlv, isaPkg::fnSrav, isaPkg::fnJr, isaPkg::fnMovz,
		isaPkg::fnMovn, isaPkg::fnMfhi, isaPkg::fnMthi, isaPkg::fnMflo, isaPkg::fnMtlo,
		isaPkg::fnMult, isaPkg::fnMultu, isaPkg::fnAdd, isaPkg::fnAddu, isaPkg::fnSub,
		isaPkg::fnAnd, isaPkg::fnOr, isaPkg::fnXor, isaPkg::fnNor, isaPkg::fnSlt,
		isaPkg::fnSltu};
	// 0..13 immediate and memory, 14..18 branches, 19..20 jumps
	logic [5:0] keptOps[21] = '{isaPkg::opAddi, isaPkg::opAddiu, isaPkg::opSlti,
		isaPkg::opSltiu, isaPkg::opAndi, isaPkg::opOri, isaPkg::opXori, isaPkg::opLui,
		isaPkg::opLb, isaPkg::opLh, isaPkg::opLw, isaPkg::opSb, isaPkg::opSh, isaPkg::opSw,
		isaPkg::opBeq, isaPkg::opBne, isaPkg::opBlez, isaPkg::opBgtz, isaPkg::opRegimm,
		isaPkg::opJ, isaPkg::opJal};

	controller dut (.*);

	initial begin
		forever #20 clk = ~clk;
	end

	function automatic logic [31:0] lfsrNext(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};	// x^32 + x^22 + x^2 + x + 1
	endfunction

	function automatic logic [31:0] randomBits(input int count);
		logic [31:0] value;
		value = '0;
		for (int i = 0; i < count; i++) begin
			lfsrState = lfsrNext(lfsrState);	// one step per bit
			value = {value[30:0], lfsrState[0]};
		end
		return value;
	endfunction

	// mem is {memWrite, memRead, memToReg}
	function automatic logic [12:0] ctrlWord(input logic aluSrc, input logic [4:0] aluOp,
		input logic regDst, input logic [1:0] addrType, input logic [2:0] mem,
		input logic regWrite);
		return {aluSrc, aluOp, regDst, addrType, mem, regWrite};
	endfunction

	function automatic logic [12:0] immCtrl(input logic [4:0] aluOp);
		return ctrlWord(1'b1, aluOp, 1'b0, controlPkg::addrWord, 3'b000, 1'b1);
	endfunction

	function automatic logic [12:0] memCtrl(input logic store, input logic [1:0] size);
		if (store)
			return ctrlWord(1'b1, controlPkg::aluAdd, 1'b0, size, 3'b100, 1'b0);
		return ctrlWord(1'b1, controlPkg::aluAdd, 1'b0, size, 3'b011, 1'b1);	// load
	endfunction

	// flags is {equalVal, gtZero, ltZero, rtIsZero}
	function automatic logic [16:0] expectedResult(input isaPkg::instrWord w,
		input logic [3:0] flags);
		logic [4:0] op;
		logic [12:0] c;
		logic [1:0] j;
		logic b;
		logic p;
		op = controlPkg::aluNone;
		c = '0;
		j = controlPkg::jumpNone;
		b = 1'b0;
		p = 1'b0;
		if (w.rType.opcode == isaPkg::opSpecial) begin
			case (w.rType.funct)
				isaPkg::fnAdd: op = controlPkg::aluAdd;
				isaPkg::fnAddu: op = controlPkg::aluAddu;
				isaPkg::fnSub: op = controlPkg::aluSub;
				isaPkg::fnMult: op = controlPkg::aluMult;
				isaPkg::fnMultu: op = controlPkg::aluMultu;
				isaPkg::fnAnd: op = controlPkg::aluAnd;
				isaPkg::fnOr: op = controlPkg::aluOr;
				isaPkg::fnNor: op = controlPkg::aluNor;
				isaPkg::fnXor: op = controlPkg::aluXor;
				isaPkg::fnSll: op = controlPkg::aluSll;
				isaPkg::fnSllv: op = controlPkg::aluSllv;
				isaPkg::fnSra: op = controlPkg::aluSra;
				isaPkg::fnSrav: op = controlPkg::aluSrav;
				isaPkg::fnSlt: op = controlPkg::aluSlt;
				isaPkg::fnSltu: op = controlPkg::aluSltu;
				isaPkg::fnMfhi: op = controlPkg::aluMfhi;
				isaPkg::fnMflo: op = controlPkg::aluMflo;
				isaPkg::fnMthi: op = controlPkg::aluMthi;
				isaPkg::fnMtlo: op = controlPkg::aluMtlo;
				isaPkg::fnMovn, isaPkg::fnMovz: op = controlPkg::aluMov;
				isaPkg::fnJr: op = controlPkg::aluAdd;
				isaPkg::fnSrl: op = w.rType.rs[0] ? controlPkg::aluRotr : controlPkg::aluSrl;
				isaPkg::fnSrlv: op = w.rType.shamt[0] ? controlPkg::aluRotrv : controlPkg::aluSrlv;
				default: op = controlPkg::aluNone;
			endcase
			if (w == '0 || op == controlPkg::aluNone)
				c = '0;	// nop or unknown funct
			else if (w.rType.funct == isaPkg::fnJr) begin
				c = ctrlWord(1'b0, op, 1'b0, controlPkg::addrWord, 3'b000, 1'b0);
				j = controlPkg::jumpRegister;
				b = 1'b1;
			end else if (w.rType.funct inside {isaPkg::fnMthi, isaPkg::fnMtlo})
				c = ctrlWord(1'b0, op, 1'b0, controlPkg::addrWord, 3'b000, 1'b0);
			else if (w.rType.funct == isaPkg::fnMovn)
				c = ctrlWord(1'b0, op, 1'b1, controlPkg::addrWord, 3'b000, !flags[0]);
			else if (w.rType.funct == isaPkg::fnMovz)
				c = ctrlWord(1'b0, op, 1'b1, controlPkg::addrWord, 3'b000, flags[0]);
			else
				c = ctrlWord(1'b0, op, 1'b1, controlPkg::addrWord, 3'b000, 1'b1);
		end else begin
			case (w.iType.opcode)
				isaPkg::opAddi: c = immCtrl(controlPkg::aluAdd);
				isaPkg::opAddiu: c = immCtrl(controlPkg::aluAddu);
				isaPkg::opSlti: c = immCtrl(controlPkg::aluSlt);
				isaPkg::opSltiu: c = immCtrl(controlPkg::aluSltu);
				isaPkg::opAndi: c = immCtrl(controlPkg::aluAnd);
				isaPkg::opOri: c = immCtrl(controlPkg::aluOr);
				isaPkg::opXori: c = immCtrl(controlPkg::aluXor);
				isaPkg::opLui: c = immCtrl(controlPkg::aluLui);
				isaPkg::opLw: c = memCtrl(1'b0, controlPkg::addrWord);
				isaPkg::opLh: c = memCtrl(1'b0, controlPkg::addrHalf);
				isaPkg::opLb: c = memCtrl(1'b0, controlPkg::addrByte);
				isaPkg::opSw: c = memCtrl(1'b1, controlPkg::addrWord);
				isaPkg::opSh: c = memCtrl(1'b1, controlPkg::addrHalf);
				isaPkg::opSb: c = memCtrl(1'b1, controlPkg::addrByte);
				isaPkg::opBeq: {b, p} = {1'b1, flags[3]};
				isaPkg::opBne: {b, p} = {1'b1, !flags[3]};
				isaPkg::opBgtz: {b, p} = {1'b1, flags[2]};
				isaPkg::opBlez: {b, p} = {1'b1, !flags[2]};
				isaPkg::opRegimm: begin
					b = w.iType.rt == isaPkg::rtBltz || w.iType.rt == isaPkg::rtBgez;
					p = (w.iType.rt == isaPkg::rtBltz && flags[1])
						|| (w.iType.rt == isaPkg::rtBgez && !flags[1]);
				end
				isaPkg::opJ: j = controlPkg::jumpTarget;
				isaPkg::opJal: begin
					j = controlPkg::jumpLink;
					c = ctrlWord(1'b0, controlPkg::aluNone, 1'b0, controlPkg::addrWord, 3'b000, 1'b1);
				end
				default: c = '0;	// unknown opcode
			endcase
		end
		return {c, j, b, p};
	endfunction

	function automatic logic isKeptOp(input logic [5:0] op);
		if (op == isaPkg::opSpecial)
			return 1'b1;
		foreach (keptOps[i])
			if (keptOps[i] == op)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic logic isKeptFunct(input logic [5:0] funct);
		foreach (keptFuncts[i])
			if (keptFuncts[i] == funct)
				return 1'b1;
		return 1'b0;
	endfunction

	function automatic isaPkg::instrWord specialWord(input logic [5:0] funct);
		isaPkg::instrWord w;
		w = randomBits(32);	// random rs, rt, rd, shamt
		w.rType.opcode = isaPkg::opSpecial;
		w.rType.funct = funct;
		return w;
	endfunction

	function automatic isaPkg::instrWord opcodeWord(input logic [5:0] op);
		isaPkg::instrWord w;
		w = randomBits(32);
		w.iType.opcode = op;
		if (op == isaPkg::opRegimm)
			w.iType.rt = {4'b0000, w.iType.rt[0]};	// bltz or bgez only
		return w;
	endfunction

	function automatic isaPkg::instrWord unknownWord();
		logic [31:0] kind;
		logic [31:0] r;
		isaPkg::instrWord w;
		kind = randomBits(2);
		w = randomBits(32);
		case (kind[1:0])
			2'd0: begin
				r = randomBits(1);
				w.rType.opcode = r[0] ? opSpecial3 : opSpecial2;
			end
			2'd1: begin
				do r = randomBits(6); while (isKeptFunct(r[5:0]));
				w.rType.opcode = isaPkg::opSpecial;	// unknown funct
				w.rType.funct = r[5:0];
			end
			2'd2: begin
				do r = randomBits(6); while (isKeptOp(r[5:0]));
				w.rType.opcode = r[5:0];
			end
			default: begin
				do r = randomBits(5); while (r[4:1] == 4'd0);	// REGIMM, not bltz/bgez
				w.iType.opcode = isaPkg::opRegimm;
				w.iType.rt = r[4:0];
			end
		endcase
		return w;
	endfunction

	function automatic isaPkg::instrWord keptWord();
		logic [31:0] r;
		int pick;
		r = randomBits(6);
		pick = int'(r[5:0]);
		if (pick < 24)
			return specialWord(keptFuncts[pick]);
		return opcodeWord(keptOps[(pick - 24) % 21]);
	endfunction

	task automatic applyWord(input isaPkg::instrWord w, input logic [3:0] flags);
		@(negedge clk);
		inValid = 1'b1;
		instruction = w;
		{equalVal, gtZero, ltZero, rtIsZero} = flags;
	endtask

	task automatic applyRandomFlags(input isaPkg::instrWord w);
		logic [31:0] r;
		r = randomBits(4);
		applyWord(w, r[3:0]);
	endtask

	task automatic idleCycle();
		@(negedge clk);
		inValid = 1'b0;
		instruction = randomBits(32);	// junk must not reach the outputs
	endtask

	task automatic reportMismatch(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		$display("ERROR at time %0t: %s expected 'h%0h, actual 'h%0h",
			$time, name, expected, actual);
		$display("Finished with errors");
		$fatal(1, "output mismatch");
	endtask

	always @(posedge clk) begin	// result due after this edge
		if (rst || !inValid) begin
			expValid <= 1'b0;
			expResult <= '0;
		end else begin
			expValid <= 1'b1;
			expResult <= expectedResult(instruction, {equalVal, gtZero, ltZero, rtIsZero});
		end
	end

	always @(negedge clk) begin	// outputs settled mid-cycle
		assert (outValid === expValid)
			else reportMismatch("outValid", 32'(expValid), 32'(outValid));
		assert (controlBits === expResult[16:4])
			else reportMismatch("controlBits", 32'(expResult[16:4]), 32'(controlBits));
		assert (jump === expResult[3:2])
			else reportMismatch("jump", 32'(expResult[3:2]), 32'(jump));
		assert (branch === expResult[1])
			else reportMismatch("branch", 32'(expResult[1]), 32'(branch));
		assert (pcSrc === expResult[0])
			else reportMismatch("pcSrc", 32'(expResult[0]), 32'(pcSrc));
	end

	always @(posedge clk) begin
		cycles++;
		if (cycles > cycleLimit) begin
			$display("Run went past %0d cycles without finishing", cycleLimit);
			$display("Finished with errors");
			$fatal(1, "timeout");
		end
	end

	initial begin
		lfsrState = 32'h7680_c078;
		rst = 1'b1;
		inValid = 1'b1;	// valid word that reset has to hold off
		instruction = opcodeWord(isaPkg::opLw);
		equalVal = 1'b0;
		gtZero = 1'b0;
		ltZero = 1'b0;
		rtIsZero = 1'b0;
		repeat (resetCycles) @(negedge clk);
		rst = 1'b0;
		inValid = 1'b0;
		idleCycle();	// first edge out of reset
		applyWord('0, 4'b1111);	// nop, flags must not leak
		foreach (keptFuncts[i])
			repeat (fieldReps) applyRandomFlags(specialWord(keptFuncts[i]));
		for (int z = 0; z < 2; z++) begin
			applyWord(specialWord(isaPkg::fnMovn), {3'b000, z[0]});
			applyWord(specialWord(isaPkg::fnMovz), {3'b000, z[0]});
		end
		idleCycle();	// drop back to zero mid-run
		for (int i = 0; i < 14; i++)
			repeat (2) applyRandomFlags(opcodeWord(keptOps[i]));
		repeat (branchReps) begin
			for (int i = 14; i < 19; i++)
				applyRandomFlags(opcodeWord(keptOps[i]));
			applyRandomFlags(opcodeWord(isaPkg::opRegimm));	// both rt selectors
		end
		repeat (2) begin
			applyRandomFlags(opcodeWord(isaPkg::opJ));
			applyRandomFlags(opcodeWord(isaPkg::opJal));
			applyRandomFlags(specialWord(isaPkg::fnJr));
		end
		repeat (unknownWords) applyRandomFlags(unknownWord());
		idleCycle();
		repeat (burstWords) applyRandomFlags(keptWord());	// inValid high throughout
		idleCycle();
		@(negedge clk);
		@(posedge clk);
		$display("Finished with no errors");
		$finish;
	end

endmodule

`default_nettype wire

/* controller.f */
source/isaPkg.sv
source/controlPkg.sv
source/specialDecode.sv
source/immediateDecode.sv
source/flowDecode.sv
source/controller.sv
bench/controllerTb.sv

/* source/controlPkg.sv */
`default_nettype none

package controlPkg;

	localparam int aluOpWidth = 5;

	localparam logic [aluOpWidth-1:0] aluNone = 5'd0;	// no ALU work
	localparam logic [aluOpWidth-1:0] aluAdd = 5'd1;	// also address calc
	localparam logic [aluOpWidth-1:0] aluAddu = 5'd2;
	localparam logic [aluOpWidth-1:0] aluSub = 5'd3;
	localparam logic [aluOpWidth-1:0] aluMult = 5'd5;
	localparam logic [aluOpWidth-1:0] aluMultu = 5'd6;
	localparam logic [aluOpWidth-1:0] aluLui = 5'd9;
	localparam logic [aluOpWidth-1:0] aluMthi = 5'd10;
	localparam logic [aluOpWidth-1:0] aluMtlo = 5'd11;
	localparam logic [aluOpWidth-1:0] aluMfhi = 5'd12;
	localparam logic [aluOpWidth-1:0] aluMflo = 5'd13;
	localparam logic [aluOpWidth-1:0] aluSra = 5'd15;
	localparam logic [aluOpWidth-1:0] aluAnd = 5'd16;
	localparam logic [aluOpWidth-1:0] aluOr = 5'd17;
	localparam logic [aluOpWidth-1:0] aluNor = 5'd18;
	localparam logic [aluOpWidth-1:0] aluXor = 5'd19;
	localparam logic [aluOpWidth-1:0] aluSll = 5'd20;
	localparam logic [aluOpWidth-1:0] aluSrl = 5'd21;
	localparam logic [aluOpWidth-1:0] aluSlt = 5'd22;
	localparam logic [aluOpWidth-1:0] aluMov = 5'd23;	// movn and movz
	localparam logic [aluOpWidth-1:0] aluRotrv = 5'd24;
	localparam logic [aluOpWidth-1:0] aluSrav = 5'd25;
	localparam logic [aluOpWidth-1:0] aluSltu = 5'd27;
	localparam logic [aluOpWidth-1:0] aluSllv = 5'd29;
	localparam logic [aluOpWidth-1:0] aluSrlv = 5'd30;
	localparam logic [aluOpWidth-1:0] aluRotr = 5'd31;

	// control word is {aluSrc, aluOp, regDst, addrType, memWrite, memRead, memToReg, regWrite}
	localparam int ctrlWidth = 13;
	localparam int aluSrcBit = 12;	// second operand from imm
	localparam int aluOpLsb = 7;	// field 11..7
	localparam int regDstBit = 6;	// write rd instead of rt
	localparam int addrTypeLsb = 4;	// field 5..4
	localparam int memWriteBit = 3;
	localparam int memReadBit = 2;
	localparam int memToRegBit = 1;	// writeback from memory
	localparam int regWriteBit = 0;

	localparam logic [1:0] addrWord = 2'd0;	// memory access size
	localparam logic [1:0] addrHalf = 2'd1;
	localparam logic [1:0] addrByte = 2'd2;

	localparam logic [1:0] jumpNone = 2'd0;	// sequential pc
	localparam logic [1:0] jumpTarget = 2'd1;	// j
	localparam logic [1:0] jumpRegister = 2'd2;	// jr
	localparam logic [1:0] jumpLink = 2'd3;	// jal

endpackage

`default_nettype wire

/* source/controller.sv */
`default_nettype none

module controller (
	input logic clk,
	input logic rst,
	input logic inValid,
	input isaPkg::instrWord instruction,
	input logic equalVal,
	input logic gtZero,
	input logic ltZero,
	input logic rtIsZero,
	output logic outValid,
	output logic [controlPkg::ctrlWidth-1:0] controlBits,
	output logic [1:0] jump,
	output logic branch,
	output logic pcSrc
);

	logic [controlPkg::ctrlWidth-1:0] specialCtrl, immCtrl, flowCtrl, nextCtrl;
	logic [1:0] specialJump, flowJump, nextJump;
	logic specialBranch, flowBranch, flowPcSrc;
	logic isSpecial;

	specialDecode specialTable (
		.instruction(instruction),
		.rtIsZero(rtIsZero),
		.ctrl(specialCtrl),
		.jump(specialJump),
		.branch(specialBranch)
	);

	immediateDecode immediateTable (
		.instruction(instruction),
		.ctrl(immCtrl)
	);

	flowDecode flowTable (
		.instruction(instruction),
		.equalVal(equalVal),
		.gtZero(gtZero),
		.ltZero(ltZero),
		.ctrl(flowCtrl),
		.jump(flowJump),
		.branch(flowBranch),
		.pcSrc(flowPcSrc)
	);

	assign isSpecial = instruction.rType.opcode == isaPkg::opSpecial;
	assign nextCtrl = isSpecial ? specialCtrl : (immCtrl | flowCtrl);	// tables are disjoint
	assign nextJump = isSpecial ? specialJump : flowJump;

	always_ff @(posedge clk) begin
		if (rst || !inValid) begin	// idle cycles show nothing
			outValid <= 1'b0;
			controlBits <= '0;
			jump <= controlPkg::jumpNone;
			branch <= 1'b0;
			pcSrc <= 1'b0;
		end else begin
			outValid <= 1'b1;
			controlBits <= nextCtrl;
			jump <= nextJump;
			branch <= isSpecial ? specialBranch : flowBranch;
			pcSrc <= !isSpecial && flowPcSrc;	// jr leaves pcSrc low
		end
	end

endmodule

`default_nettype wire

/* source/flowDecode.sv */
`default_nettype none

module flowDecode (
	input isaPkg::instrWord instruction,
	input logic equalVal,	// rs == rt
	input logic gtZero,	// rs > 0
	input logic ltZero,	// rs < 0
	output logic [controlPkg::ctrlWidth-1:0] ctrl,
	output logic [1:0] jump,
	output logic branch,
	output logic pcSrc
);

	logic link;	// jal writes return address

	always_comb begin
		jump = controlPkg::jumpNone;
		branch = 1'b0;
		pcSrc = 1'b0;
		link = 1'b0;
		case (instruction.iType.opcode)
			isaPkg::opBeq: begin
				branch = 1'b1;
				pcSrc = equalVal;
			end
			isaPkg::opBne: begin
				branch = 1'b1;
				pcSrc = ~equalVal;
			end
			isaPkg::opBgtz: begin
				branch = 1'b1;
				pcSrc = gtZero;
			end
			isaPkg::opBlez: begin
				branch = 1'b1;
				pcSrc = ~gtZero;	// zero or negative
			end
			isaPkg::opRegimm: begin
				case (instruction.iType.rt)	// rt picks the condition
					isaPkg::rtBltz: begin
						branch = 1'b1;
						pcSrc = ltZero;
					end
					isaPkg::rtBgez: begin
						branch = 1'b1;
						pcSrc = ~ltZero;
					end
					default: branch = 1'b0;	// other REGIMM not supported
				endcase
			end
			isaPkg::opJ: jump = controlPkg::jumpTarget;
			isaPkg::opJal: begin
				jump = controlPkg::jumpLink;
				link = 1'b1;
			end
			default: jump = controlPkg::jumpNone;
		endcase
	end

	always_comb begin
		ctrl = '0;	// branches need no datapath control
		ctrl[controlPkg::regWriteBit] = link;
	end

endmodule

`default_nettype wire

/* source/immediateDecode.sv */
`default_nettype none

module immediateDecode (
	input isaPkg::instrWord instruction,
	output logic [controlPkg::ctrlWidth-1:0] ctrl
);

	logic [controlPkg::aluOpWidth-1:0] aluOp;
	logic [1:0] addrType;
	logic aluSrc;
	logic regWrite;
	logic load;	// memRead and memToReg together
	logic store;

	always_comb begin
		aluOp = controlPkg::aluAdd;	// loads and stores add base + offset
		addrType = controlPkg::addrWord;
		aluSrc = 1'b1;	// every owned opcode takes imm
		regWrite = 1'b1;
		load = 1'b0;
		store = 1'b0;
		case (instruction.iType.opcode)
			isaPkg::opAddi: aluOp = controlPkg::aluAdd;
			isaPkg::opAddiu: aluOp = controlPkg::aluAddu;
			isaPkg::opSlti: aluOp = controlPkg::aluSlt;
			isaPkg::opSltiu: aluOp = controlPkg::aluSltu;
			isaPkg::opAndi: aluOp = controlPkg::aluAnd;
			isaPkg::opOri: aluOp = controlPkg::aluOr;
			isaPkg::opXori: aluOp = controlPkg::aluXor;
			isaPkg::opLui: aluOp = controlPkg::aluLui;	// imm to upper half
			isaPkg::opLw: load = 1'b1;
			isaPkg::opLh: begin
				load = 1'b1;
				addrType = controlPkg::addrHalf;
			end
			isaPkg::opLb: begin
				load = 1'b1;
				addrType = controlPkg::addrByte;
			end
			isaPkg::opSw: store = 1'b1;
			isaPkg::opSh: begin
				store = 1'b1;
				addrType = controlPkg::addrHalf;
			end
			isaPkg::opSb: begin
				store = 1'b1;
				addrType = controlPkg::addrByte;
			end
			default: begin	// not ours
				aluOp = controlPkg::aluNone;
				aluSrc = 1'b0;
			end
		endcase
		if (store || !aluSrc)
			regWrite = 1'b0;	// stores and foreign opcodes never write
	end

	always_comb begin
		ctrl = '0;	// rt is the destination here
		ctrl[controlPkg::aluSrcBit] = aluSrc;
		ctrl[controlPkg::aluOpLsb +: controlPkg::aluOpWidth] = aluOp;
		ctrl[controlPkg::addrTypeLsb +: 2] = addrType;
		ctrl[controlPkg::memWriteBit] = store;
		ctrl[controlPkg::memReadBit] = load;
		ctrl[controlPkg::memToRegBit] = load;
		ctrl[controlPkg::regWriteBit] = regWrite;
	end

endmodule

`default_nettype wire

/* source/isaPkg.sv */
`default_nettype none

package isaPkg;

	localparam int opcodeWidth = 6;	// major opcode field
	localparam int regWidth = 5;	// register specifier, also shamt
	localparam int functWidth = 6;	// SPECIAL sub-opcode
	localparam int instrWidth = 32;

	// one word, three ways to look at it
	typedef union packed {
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [regWidth-1:0] rs;
			logic [regWidth-1:0] rt;
			logic [regWidth-1:0] rd;
			logic [regWidth-1:0] shamt;
			logic [functWidth-1:0] funct;
		} rType;	// register form
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [regWidth-1:0] rs;
			logic [regWidth-1:0] rt;
			logic [15:0] imm;
		} iType;	// immediate form
		struct packed {
			logic [opcodeWidth-1:0] opcode;
			logic [25:0] target;	// word index inside the 256MB region
		} jType;
	} instrWord;

	localparam logic [opcodeWidth-1:0] opSpecial = 6'b000000;	// decoded by funct
	localparam logic [opcodeWidth-1:0] opRegimm = 6'b000001;	// decoded by rt
	localparam logic [opcodeWidth-1:0] opJ = 6'b000010;
	localparam logic [opcodeWidth-1:0] opJal = 6'b000011;
	localparam logic [opcodeWidth-1:0] opBeq = 6'b000100;
	localparam logic [opcodeWidth-1:0] opBne = 6'b000101;
	localparam logic [opcodeWidth-1:0] opBlez = 6'b000110;
	localparam logic [opcodeWidth-1:0] opBgtz = 6'b000111;
	localparam logic [opcodeWidth-1:0] opAddi = 6'b001000;
	localparam logic [opcodeWidth-1:0] opAddiu = 6'b001001;
	localparam logic [opcodeWidth-1:0] opSlti = 6'b001010;
	localparam logic [opcodeWidth-1:0] opSltiu = 6'b001011;
	localparam logic [opcodeWidth-1:0] opAndi = 6'b001100;
	localparam logic [opcodeWidth-1:0] opOri = 6'b001101;
	localparam logic [opcodeWidth-1:0] opXori = 6'b001110;
	localparam logic [opcodeWidth-1:0] opLui = 6'b001111;
	localparam logic [opcodeWidth-1:0] opLb = 6'b100000;
	localparam logic [opcodeWidth-1:0] opLh = 6'b100001;
	localparam logic [opcodeWidth-1:0] opLw = 6'b100011;
	localparam logic [opcodeWidth-1:0] opSb = 6'b101000;
	localparam logic [opcodeWidth-1:0] opSh = 6'b101001;
	localparam logic [opcodeWidth-1:0] opSw = 6'b101011;

	localparam logic [functWidth-1:0] fnSll = 6'b000000;	// all-zero word is nop
	localparam logic [functWidth-1:0] fnSrl = 6'b000010;	// rotr shares it
	localparam logic [functWidth-1:0] fnSra = 6'b000011;
	localparam logic [functWidth-1:0] fnSllv = 6'b000100;
	localparam logic [functWidth-1:0] fnSrlv = 6'b000110;	// rotrv shares it
	localparam logic [functWidth-1:0] fnSrav = 6'b000111;
	localparam logic [functWidth-1:0] fnJr = 6'b001000;
	localparam logic [functWidth-1:0] fnMovz = 6'b001010;
	localparam logic [functWidth-1:0] fnMovn = 6'b001011;
	localparam logic [functWidth-1:0] fnMfhi = 6'b010000;
	localparam logic [functWidth-1:0] fnMthi = 6'b010001;
	localparam logic [functWidth-1:0] fnMflo = 6'b010010;
	localparam logic [functWidth-1:0] fnMtlo = 6'b010011;
	localparam logic [functWidth-1:0] fnMult = 6'b011000;
	localparam logic [functWidth-1:0] fnMultu = 6'b011001;
	localparam logic [functWidth-1:0] fnAdd = 6'b100000;
	localparam logic [functWidth-1:0] fnAddu = 6'b100001;
	localparam logic [functWidth-1:0] fnSub = 6'b100010;
	localparam logic [functWidth-1:0] fnAnd = 6'b100100;
	localparam logic [functWidth-1:0] fnOr = 6'b100101;
	localparam logic [functWidth-1:0] fnXor = 6'b100110;
	localparam logic [functWidth-1:0] fnNor = 6'b100111;
	localparam logic [functWidth-1:0] fnSlt = 6'b101010;
	localparam logic [functWidth-1:0] fnSltu = 6'b101011;

	localparam logic [regWidth-1:0] rtBltz = 5'b00000;	// REGIMM rt selectors
	localparam logic [regWidth-1:0] rtBgez = 5'b00001;

	localparam int rotateBit = 21;	// rs lsb, set for rotr
	localparam int rotateVarBit = 6;	// shamt lsb, set for rotrv

endpackage

`default_nettype wire

/* source/specialDecode.sv */
`default_nettype none

module specialDecode (
	input isaPkg::instrWord instruction,
	input logic rtIsZero,	// rt register reads zero
	output logic [controlPkg::ctrlWidth-1:0] ctrl,
	output logic [1:0] jump,
	output logic branch
);

	logic [controlPkg::aluOpWidth-1:0] aluOp;
	logic regDst;
	logic regWrite;
	logic isNop;
	logic owned;

	assign isNop = instruction == {isaPkg::instrWidth{1'b0}};	// sll r0,r0,0
	assign owned = (instruction.rType.opcode == isaPkg::opSpecial) && !isNop;

	always_comb begin
		aluOp = controlPkg::aluNone;
		regDst = 1'b0;
		regWrite = 1'b0;
		jump = controlPkg::jumpNone;
		branch = 1'b0;
		if (owned) begin
			regDst = 1'b1;	// most functs write rd
			regWrite = 1'b1;
			case (instruction.rType.funct)
				isaPkg::fnAdd: aluOp = controlPkg::aluAdd;
				isaPkg::fnAddu: aluOp = controlPkg::aluAddu;
				isaPkg::fnSub: aluOp = controlPkg::aluSub;
				isaPkg::fnMult: aluOp = controlPkg::aluMult;	// still flags a write
				isaPkg::fnMultu: aluOp = controlPkg::aluMultu;
				isaPkg::fnAnd: aluOp = controlPkg::aluAnd;
				isaPkg::fnOr: aluOp = controlPkg::aluOr;
				isaPkg::fnNor: aluOp = controlPkg::aluNor;
				isaPkg::fnXor: aluOp = controlPkg::aluXor;
				isaPkg::fnSll: aluOp = controlPkg::aluSll;
				isaPkg::fnSllv: aluOp = controlPkg::aluSllv;
				isaPkg::fnSra: aluOp = controlPkg::aluSra;
				isaPkg::fnSrav: aluOp = controlPkg::aluSrav;
				isaPkg::fnSlt: aluOp = controlPkg::aluSlt;
				isaPkg::fnSltu: aluOp = controlPkg::aluSltu;
				isaPkg::fnMfhi: aluOp = controlPkg::aluMfhi;
				isaPkg::fnMflo: aluOp = controlPkg::aluMflo;
				isaPkg::fnSrl: begin
					if (instruction[isaPkg::rotateBit])	// R bit in rs field
						aluOp = controlPkg::aluRotr;
					else
						aluOp = controlPkg::aluSrl;
				end
				isaPkg::fnSrlv: begin
					if (instruction[isaPkg::rotateVarBit])	// R bit in shamt field
						aluOp = controlPkg::aluRotrv;
					else
						aluOp = controlPkg::aluSrlv;
				end
				isaPkg::fnMovn: begin
					aluOp = controlPkg::aluMov;
					regWrite = ~rtIsZero;	// move only if rt nonzero
				end
				isaPkg::fnMovz: begin
					aluOp = controlPkg::aluMov;
					regWrite = rtIsZero;
				end
				isaPkg::fnMthi: begin
					aluOp = controlPkg::aluMthi;	// writes hi, not the file
					regDst = 1'b0;
					regWrite = 1'b0;
				end
				isaPkg::fnMtlo: begin
					aluOp = controlPkg::aluMtlo;
					regDst = 1'b0;
					regWrite = 1'b0;
				end
				isaPkg::fnJr: begin
					aluOp = controlPkg::aluAdd;
					regDst = 1'b0;
					regWrite = 1'b0;
					jump = controlPkg::jumpRegister;	// pc from rs
					branch = 1'b1;
				end
				default: begin	// unknown funct
					regDst = 1'b0;
					regWrite = 1'b0;
				end
			endcase
		end
	end

	always_comb begin
		ctrl = '0;	// no imm, no memory on R-type
		ctrl[controlPkg::aluOpLsb +: controlPkg::aluOpWidth] = aluOp;
		ctrl[controlPkg::regDstBit] = regDst;
		ctrl[controlPkg::regWriteBit] = regWrite;
	end

endmodule

`default_nettype wire
